// ==== source/obj_pkg.sv ====
package obj_pkg;

    // table geometry
    localparam int TABLE_AW_DEF = 9;     // 128 objects, four words each
    localparam int WORD_W       = 16;

    // word index inside one entry
    localparam logic [1:0] ATTR_IDX = 2'd0;
    localparam logic [1:0] CODE_IDX = 2'd1;
    localparam logic [1:0] XPOS_IDX = 2'd2;

    // attribute word fields
    localparam int VSUB_LSB  = 8;
    localparam int VSUB_W    = 4;
    localparam int HFLIP_BIT = 5;
    localparam int PAL_LSB   = 0;

    // x word holds a 9 bit position
    localparam int XPOS_W = 9;

    // attr and code all ones plus this x closes the table
    localparam logic [XPOS_W-1:0] END_X = '1;

endpackage

// ==== source/gfx_pkg.sv ====
package gfx_pkg;

    localparam int COLOR_W = 4;
    localparam int PAL_W   = 5;
    localparam int PIX_W   = PAL_W + COLOR_W;  // palette above colour

    localparam int LINE_AW = 9;                // 512 positions per line

    // tile ROM, code and vsub form the address
    localparam int ROM_AW = 20;
    localparam int ROM_DW = 32;

    localparam logic [COLOR_W-1:0] TRANSPARENT = 4'hF;
    localparam logic [PIX_W-1:0]   CLEAR_PIX   = '1;

endpackage

// ==== source/obj_table.sv ====
`timescale 1ns/1ns

module obj_table #(
    parameter int TABLE_AW = obj_pkg::TABLE_AW_DEF
) (
    input  logic                        clk,

    // host side
    input  logic                        tbl_we,
    input  logic [TABLE_AW-1:0]         tbl_addr,
    input  logic [obj_pkg::WORD_W-1:0]  tbl_wdata,

    // scanner side
    input  logic [TABLE_AW-1:0]         table_addr,
    output logic [obj_pkg::WORD_W-1:0]  table_data
);

    import obj_pkg::*;

    // four words per object, fourth one unused
    logic [WORD_W-1:0] mem [2**TABLE_AW];

    // host port only writes
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_wdata;
        end
    end

    // registered read, data one cycle after table_addr
    always_ff @(posedge clk) begin
        table_data <= mem[table_addr];
    end

endmodule

// ==== source/obj_draw.sv ====
`timescale 1ns/1ns

module obj_draw #(
    parameter int TABLE_AW = obj_pkg::TABLE_AW_DEF
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        start,
    output logic                        done,

    // object table read port
    output logic [TABLE_AW-1:0]         table_addr,
    input  logic [obj_pkg::WORD_W-1:0]  table_data,

    // current object for the tile drawer
    output logic [obj_pkg::WORD_W-1:0]  obj_code,
    output logic [obj_pkg::WORD_W-1:0]  obj_attr,
    output logic [gfx_pkg::LINE_AW-1:0] obj_hpos,
    output logic                        tile_start,
    input  logic                        tile_idle
);

    import obj_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,     // first address in flight
        S_ATTR,
        S_CODE,
        S_XPOS,
        S_LAUNCH,
        S_PULSE,
        S_BUSY
    } state_t;

    state_t            state;
    logic [TABLE_AW-3:0] entry;     // object number
    logic [1:0]        word;        // word inside the entry
    logic              end_mark;

    assign table_addr = {entry, word};

    // x arrives on table_data while attr and code are already held
    assign end_mark = (&obj_attr) && (&obj_code) && (table_data[XPOS_W-1:0] == END_X);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            entry      <= '0;
            word       <= ATTR_IDX;
            done       <= 1'b0;
            tile_start <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        entry <= '0;
                        word  <= ATTR_IDX;
                        done  <= 1'b0;
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    word  <= CODE_IDX;   // RAM is latching the attr word now
                    state <= S_ATTR;
                end
                S_ATTR: begin
                    word  <= XPOS_IDX;
                    state <= S_CODE;
                end
                S_CODE: begin
                    state <= S_XPOS;
                end
                S_XPOS: begin
                    if (end_mark) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        state <= S_LAUNCH;
                    end
                end
                S_LAUNCH: begin
                    if (tile_idle) begin
                        tile_start <= 1'b1;
                        state      <= S_PULSE;
                    end
                end
                S_PULSE: begin
                    tile_start <= 1'b0;  // drawer drops idle on this edge
                    state      <= S_BUSY;
                end
                S_BUSY: begin
                    if (tile_idle) begin
                        if (&entry) begin
                            // last table entry drawn
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            entry <= entry + 1'b1;
                            word  <= ATTR_IDX;
                            state <= S_WAIT;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // object fields, captured as they come out of the RAM
    always_ff @(posedge clk) begin
        case (state)
            S_ATTR: obj_attr <= table_data;
            S_CODE: obj_code <= table_data;
            S_XPOS: obj_hpos <= table_data[XPOS_W-1:0] - 1'b1;  // drawer pre-increments
            default: ;
        endcase
    end

endmodule

// ==== source/obj_tile.sv ====
`timescale 1ns/1ns

module obj_tile (
    input  logic                        clk,
    input  logic                        rst,

    // object from the scanner
    input  logic [obj_pkg::WORD_W-1:0]  obj_code,
    input  logic [obj_pkg::WORD_W-1:0]  obj_attr,
    input  logic [gfx_pkg::LINE_AW-1:0] obj_hpos,
    input  logic                        tile_start,
    output logic                        tile_idle,

    // line buffer write port
    output logic [gfx_pkg::LINE_AW-1:0] buf_addr,
    output logic [gfx_pkg::PIX_W-1:0]   buf_data,
    output logic                        buf_wr,

    // tile ROM
    output logic [gfx_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        rom_half,
    output logic                        rom_cs,
    input  logic [gfx_pkg::ROM_DW-1:0]  rom_data,
    input  logic                        rom_ok
);

    import obj_pkg::*;
    import gfx_pkg::*;

    logic [VSUB_W-1:0] vsub;
    logic [PAL_W-1:0]  pal;
    logic              hflip;

    logic              draw;        // shifting pixels out
    logic [2:0]        cnt;         // pixel within the word
    logic [1:0]        pend;        // halves still to accept
    logic [1:0]        hold;        // rom_ok blanking after a word
    logic [ROM_DW-1:0] pxl;
    logic              rom_good;
    logic              launch;
    logic              accept;
    logic              blank_word;

    assign vsub  = obj_attr[VSUB_LSB +: VSUB_W];
    assign hflip = obj_attr[HFLIP_BIT];
    assign pal   = obj_attr[PAL_LSB +: PAL_W];

    assign rom_good   = rom_ok && (hold == 2'b00);
    assign launch     = tile_idle && tile_start;
    assign accept     = !tile_idle && !draw && (pend != 2'b00) && rom_good;
    assign blank_word = &rom_data;

    // one bit from each plane, MSB plane first
    function automatic logic [COLOR_W-1:0] pix_colour(
        input logic [ROM_DW-1:0] w,
        input logic              flip
    );
        if (flip) begin
            return {w[24], w[16], w[8], w[0]};
        end
        return {w[31], w[23], w[15], w[7]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_idle <= 1'b1;
            rom_cs    <= 1'b0;
            buf_wr    <= 1'b0;
            draw      <= 1'b0;
            cnt       <= '0;
            pend      <= '0;
            hold      <= '0;
        end else begin
            buf_wr <= 1'b0;
            hold   <= hold >> 1;
            if (tile_idle) begin
                if (tile_start) begin
                    tile_idle <= 1'b0;
                    rom_cs    <= 1'b1;
                    pend      <= 2'b11;
                    hold      <= 2'b11;
                end
            end else if (draw) begin
                buf_wr <= 1'b1;
                cnt    <= cnt + 1'b1;
                if (&cnt) begin
                    draw <= 1'b0;
                end
            end else if (pend == 2'b00) begin
                tile_idle <= 1'b1;       // one cycle after the last write
            end else if (rom_good) begin
                hold <= 2'b11;           // old rom_ok may still be up
                pend <= pend >> 1;
                if (!pend[1]) begin
                    rom_cs <= 1'b0;      // second half in
                end
                if (!blank_word) begin
                    draw <= 1'b1;
                    cnt  <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            rom_addr <= {obj_code, vsub};
            rom_half <= hflip;           // flipped tiles start with the right half
            buf_addr <= obj_hpos;
        end else if (accept) begin
            pxl <= rom_data;
            if (pend[1]) begin
                rom_half <= ~rom_half;
            end
            if (blank_word) begin
                buf_addr <= buf_addr + 9'd8;  // nothing to draw, wraps at 512
            end
        end else if (draw) begin
            buf_addr <= buf_addr + 1'b1;
            buf_data <= {pal, pix_colour(pxl, hflip)};
            pxl      <= hflip ? pxl >> 1 : pxl << 1;
        end
    end

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        swap,

    // drawing side
    input  logic [gfx_pkg::LINE_AW-1:0] buf_addr,
    input  logic [gfx_pkg::PIX_W-1:0]   buf_data,
    input  logic                        buf_wr,

    // video side
    input  logic [gfx_pkg::LINE_AW-1:0] rd_addr,
    input  logic                        rd_en,
    output logic [gfx_pkg::PIX_W-1:0]   rd_data
);

    import gfx_pkg::*;

    logic bank;         // bank being drawn, the other one is on screen
    logic rd_sel;       // bank that produced the last read

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (swap) begin
            bank <= ~bank;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_sel <= ~bank;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        localparam logic BANK_ID = (b == 1);

        logic [PIX_W-1:0] mem [2**LINE_AW];
        logic [PIX_W-1:0] q;

        // both banks power up blank
        initial begin
            for (int i = 0; i < 2**LINE_AW; i++) begin
                mem[i] = CLEAR_PIX;
            end
        end

        always_ff @(posedge clk) begin
            if (bank == BANK_ID) begin
                if (buf_wr && buf_data[COLOR_W-1:0] != TRANSPARENT) begin
                    mem[buf_addr] <= buf_data;
                end
            end else if (rd_en) begin
                q             <= mem[rd_addr];
                mem[rd_addr]  <= CLEAR_PIX;     // ready for the next line
            end
        end
    end

    assign rd_data = rd_sel ? g_bank[1].q : g_bank[0].q;

endmodule

// ==== source/obj_line_top.sv ====
`timescale 1ns/1ns

module obj_line_top #(
    parameter int TABLE_AW = obj_pkg::TABLE_AW_DEF
) (
    input  logic                        clk,
    input  logic                        rst,

    // host writes to the object table
    input  logic                        tbl_we,
    input  logic [TABLE_AW-1:0]         tbl_addr,
    input  logic [obj_pkg::WORD_W-1:0]  tbl_wdata,

    input  logic                        line_start,
    output logic                        draw_done,

    // video readout
    input  logic [gfx_pkg::LINE_AW-1:0] rd_addr,
    input  logic                        rd_en,
    output logic [gfx_pkg::PIX_W-1:0]   rd_data,

    // tile ROM
    output logic [gfx_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        rom_half,
    output logic                        rom_cs,
    input  logic [gfx_pkg::ROM_DW-1:0]  rom_data,
    input  logic                        rom_ok
);

    import obj_pkg::*;
    import gfx_pkg::*;

    logic [TABLE_AW-1:0] table_addr;
    logic [WORD_W-1:0]   table_data;
    logic [WORD_W-1:0]   obj_code;
    logic [WORD_W-1:0]   obj_attr;
    logic [LINE_AW-1:0]  obj_hpos;
    logic                tile_start;
    logic                tile_idle;
    logic [LINE_AW-1:0]  buf_addr;
    logic [PIX_W-1:0]    buf_data;
    logic                buf_wr;

    obj_table #(.TABLE_AW(TABLE_AW)) u_table (
        .clk        (clk),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_wdata  (tbl_wdata),
        .table_addr (table_addr),
        .table_data (table_data)
    );

    obj_draw #(.TABLE_AW(TABLE_AW)) u_draw (
        .clk        (clk),
        .rst        (rst),
        .start      (line_start),
        .done       (draw_done),
        .table_addr (table_addr),
        .table_data (table_data),
        .obj_code   (obj_code),
        .obj_attr   (obj_attr),
        .obj_hpos   (obj_hpos),
        .tile_start (tile_start),
        .tile_idle  (tile_idle)
    );

    obj_tile u_tile (
        .clk        (clk),
        .rst        (rst),
        .obj_code   (obj_code),
        .obj_attr   (obj_attr),
        .obj_hpos   (obj_hpos),
        .tile_start (tile_start),
        .tile_idle  (tile_idle),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .buf_wr     (buf_wr),
        .rom_addr   (rom_addr),
        .rom_half   (rom_half),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok)
    );

    // banks swap on the same pulse that starts the scan
    line_buffer u_buf (
        .clk        (clk),
        .rst        (rst),
        .swap       (line_start),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .buf_wr     (buf_wr),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_data    (rd_data)
    );

endmodule

// ==== sim/obj_line_props.sv ====
`timescale 1ns/1ns

module obj_line_props (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic done,
    input  logic tile_start,
    input  logic tile_idle,
    input  logic buf_wr,
    input  logic rom_cs
);

    logic started;      // a line start seen since reset
    logic tile_seen;    // first tile launch seen

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started   <= 1'b0;
            tile_seen <= 1'b0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (tile_start) begin
                tile_seen <= 1'b1;
            end
        end
    end

    // the first start after reset comes with done still low
    start_when_done: assert property (@(posedge clk) disable iff (rst)
        start |-> (done || !started))
        else $error("line start arrived while the scan was unfinished");

    no_write_when_idle: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> !tile_idle)
        else $error("line buffer write while the tile drawer is idle");

    quiet_rom_at_start: assert property (@(posedge clk) disable iff (rst)
        !tile_seen |-> !rom_cs)
        else $error("ROM request before the first tile start");

endmodule

// scanner side, drawer signals tied off
bind obj_draw obj_line_props u_draw_props (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .done       (done),
    .tile_start (tile_start),
    .tile_idle  (tile_idle),
    .buf_wr     (1'b0),
    .rom_cs     (1'b0)
);

// drawer side, scanner strobes tied off
bind obj_tile obj_line_props u_tile_props (
    .clk        (clk),
    .rst        (rst),
    .start      (1'b0),
    .done       (1'b1),
    .tile_start (tile_start),
    .tile_idle  (tile_idle),
    .buf_wr     (buf_wr),
    .rom_cs     (rom_cs)
);

// ==== sim/obj_line_tb.sv ====
`timescale 1ns/1ns

module obj_line_tb;

    import obj_pkg::*;
    import gfx_pkg::*;

    localparam int TABLE_AW = TABLE_AW_DEF;
    localparam int N_OBJ    = 2**(TABLE_AW-2);
    localparam int LINE_LEN = 2**LINE_AW;
    localparam int TIMEOUT  = 20000;     // cycles allowed for one line

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 tbl_we;
    logic [TABLE_AW-1:0]  tbl_addr;
    logic [WORD_W-1:0]    tbl_wdata;
    logic                 line_start;
    logic                 draw_done;
    logic [LINE_AW-1:0]   rd_addr;
    logic                 rd_en;
    logic [PIX_W-1:0]     rd_data;
    logic [ROM_AW-1:0]    rom_addr;
    logic                 rom_half;
    logic                 rom_cs;
    logic [ROM_DW-1:0]    rom_data;
    logic                 rom_ok;

    // host copy of the table
    logic [WORD_W-1:0]    m_attr [N_OBJ];
    logic [WORD_W-1:0]    m_code [N_OBJ];
    logic [WORD_W-1:0]    m_x    [N_OBJ];
    int                   n_obj;

    logic [PIX_W-1:0]     shown [LINE_LEN];  // what the display bank must hold
    int                   pix_errors;
    int                   other_errors;
    int                   rom_reqs;

    obj_line_top #(.TABLE_AW(TABLE_AW)) uut (
        .clk        (clk),
        .rst        (rst),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_wdata  (tbl_wdata),
        .line_start (line_start),
        .draw_done  (draw_done),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rom_addr   (rom_addr),
        .rom_half   (rom_half),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok)
    );

    always #4 clk = ~clk;

    // tile data, a hash of address and half
    function automatic logic [ROM_DW-1:0] rom_word(
        input logic [ROM_AW-1:0] addr,
        input logic              half
    );
        logic [31:0] h;
        logic [31:0] w;
        int          i;
        h = 32'({addr, half}) * 32'h9E3779B1;
        h = h ^ (h >> 15);
        h = h * 32'h85EBCA6B;
        h = h ^ (h >> 13);
        if (h[31:29] == 3'd0) begin
            return '1;                     // blank word, about one in eight
        end
        w = h * 32'hC2B2AE35;
        w = w ^ (w >> 16);
        for (i = 0; i < 8; i++) begin
            if (h[i] && h[i+8]) begin
                w = w | (32'h80808080 >> i);  // force colour 15 on this pixel
            end
        end
        return w;
    endfunction

    // ROM answers each new address/half after 1 to 6 cycles, holds rom_ok
    initial begin : rom_model
        logic [ROM_AW-1:0] req_addr;
        logic              req_half;
        logic              have_req;
        int                delay;
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_reqs = 0;
        req_addr = '0;
        req_half = 1'b0;
        have_req = 1'b0;
        delay    = 0;
        forever begin
            @(posedge clk);
            if (rst || !rom_cs) begin
                have_req = 1'b0;
                rom_ok  <= 1'b0;
            end else if (!have_req || rom_addr != req_addr || rom_half != req_half) begin
                have_req = 1'b1;
                req_addr = rom_addr;
                req_half = rom_half;
                delay    = 1 + int'($urandom % 6);
                rom_reqs++;
                rom_ok  <= 1'b0;
            end else if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(req_addr, req_half);
                end
            end
        end
    end

    task automatic make_table(input int n, input logic flip, input int x_base, input int x_span);
        int k;
        n_obj = n;
        for (k = 0; k < n; k++) begin
            m_attr[k] = 16'($urandom);
            m_attr[k][HFLIP_BIT] = flip ? 1'($urandom) : 1'b0;
            m_code[k] = 16'($urandom);
            if (&m_code[k]) begin
                m_code[k][0] = 1'b0;        // keep clear of the end marker
            end
            m_x[k] = 16'($urandom);
            m_x[k][XPOS_W-1:0] = XPOS_W'(x_base + int'($urandom % x_span));
        end
    endtask

    task automatic write_word(input int addr, input logic [WORD_W-1:0] data);
        @(posedge clk);
        tbl_we    <= 1'b1;
        tbl_addr  <= TABLE_AW'(addr);
        tbl_wdata <= data;
    endtask

    task automatic load_table();
        int k;
        for (k = 0; k < n_obj; k++) begin
            write_word(4*k + ATTR_IDX, m_attr[k]);
            write_word(4*k + CODE_IDX, m_code[k]);
            write_word(4*k + XPOS_IDX, m_x[k]);
            write_word(4*k + 3, 16'($urandom));   // unused word
        end
        if (n_obj < N_OBJ) begin
            write_word(4*n_obj + ATTR_IDX, '1);
            write_word(4*n_obj + CODE_IDX, '1);
            write_word(4*n_obj + XPOS_IDX, 16'(END_X));
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // expected line from the pixel rule, later objects on top
    task automatic draw_model();
        int                 p;
        int                 n;
        int                 hf;
        int                 i;
        logic               flip;
        logic [ROM_AW-1:0]  ra;
        logic [ROM_DW-1:0]  w;
        logic [COLOR_W-1:0] c;
        logic [LINE_AW-1:0] pos;
        for (p = 0; p < LINE_LEN; p++) begin
            shown[p] = CLEAR_PIX;
        end
        for (n = 0; n < n_obj; n++) begin
            flip = m_attr[n][HFLIP_BIT];
            ra   = {m_code[n], m_attr[n][VSUB_LSB +: VSUB_W]};
            for (hf = 0; hf < 2; hf++) begin
                w = rom_word(ra, flip ^ hf[0]);     // flipped tiles fetch half 1 first
                if (w != '1) begin
                    for (i = 0; i < 8; i++) begin
                        if (flip) begin
                            c = {w[24+i], w[16+i], w[8+i], w[i]};
                        end else begin
                            c = {w[31-i], w[23-i], w[15-i], w[7-i]};
                        end
                        pos = LINE_AW'(m_x[n][XPOS_W-1:0] + 8*hf + i);
                        if (c != TRANSPARENT) begin
                            shown[pos] = {m_attr[n][PAL_LSB +: PAL_W], c};
                        end
                    end
                end
            end
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!draw_done && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!draw_done) begin
            $display("timeout: draw_done did not rise within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    endtask

    // start a line, read out the previous one, then wait for the scan
    task automatic run_line();
        int a;
        @(posedge clk);
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
        @(negedge clk);
        assert (!draw_done) else begin
            other_errors++;
            $display("FAIL at %0t ns: draw_done = %b, expected 0", $time, draw_done);
        end
        for (a = 0; a < LINE_LEN; a++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= LINE_AW'(a);
            @(posedge clk);
            rd_en   <= 1'b0;
            @(negedge clk);
            assert (rd_data == shown[a]) else begin
                pix_errors++;
                $display("FAIL at %0t ns: rd_data[%0d] = %h, expected %h",
                         $time, a, rd_data, shown[a]);
            end
        end
        wait_done();
        draw_model();
    endtask

    initial begin : main
        int t;
        rst          = 1'b1;
        tbl_we       = 1'b0;
        tbl_addr     = '0;
        tbl_wdata    = '0;
        line_start   = 1'b0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        pix_errors   = 0;
        other_errors = 0;
        void'($urandom(94812));
        for (t = 0; t < LINE_LEN; t++) begin
            shown[t] = CLEAR_PIX;               // both banks start blank
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // end marker first, no ROM traffic expected
        make_table(0, 1'b0, 0, LINE_LEN);
        load_table();
        run_line();
        run_line();
        assert (rom_reqs == 0) else begin
            other_errors++;
            $display("ROM was requested %0d times while the table was empty", rom_reqs);
        end

        for (t = 0; t < 4; t++) begin
            make_table(1 + int'($urandom % 20), 1'b0, 0, LINE_LEN);
            load_table();
            run_line();
        end
        for (t = 0; t < 4; t++) begin
            make_table(1 + int'($urandom % 20), 1'b1, 0, LINE_LEN);
            load_table();
            run_line();
        end
        for (t = 0; t < 4; t++) begin
            make_table(2 + int'($urandom % 19), 1'b1, 500, 24);  // stacked around 511
            load_table();
            run_line();
        end

        make_table(N_OBJ, 1'b1, 0, LINE_LEN);   // no end marker
        load_table();
        run_line();

        // blank lines, each bank must read back cleared
        make_table(0, 1'b0, 0, LINE_LEN);
        load_table();
        repeat (3) run_line();

        $display("errors: %0d pixel, %0d other", pix_errors, other_errors);
        if (pix_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/obj_pkg.sv
source/gfx_pkg.sv
source/obj_table.sv
source/obj_draw.sv
source/obj_tile.sv
source/line_buffer.sv
source/obj_line_top.sv
sim/obj_line_props.sv
sim/obj_line_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sprite line testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module obj_line_tb -Mdir "$BUILD_DIR" -o obj_line_sim \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/obj_line_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
